//--- logic/endpoint_pkg.sv
package endpoint_pkg;

    // Basic scalar types
    typedef logic [31:0] word_t;
    typedef logic [3:0]  node_id_t;
    typedef logic [7:0]  msg_len_t;

    // Transmit FIFO level as seen by the send check, wide enough for any length
    typedef logic [$bits(msg_len_t):0] tx_level_t;

    // One link flit, the same format in both directions
    typedef struct packed {
        logic  valid;
        word_t data;
    } flit_t;

    // Layout of the data word of a header flit
    typedef struct packed {
        node_id_t    dest;
        node_id_t    src;
        msg_len_t    length;
        logic [15:0] reserved;
    } header_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        wen;
        logic        ren;
        word_t       wdata;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
    } bus_rsp_t;

    // Per-packet receive record, bit order matches the request read word
    typedef struct packed {
        node_id_t src;
        msg_len_t length;
        logic     overflow;
    } rx_meta_t;

    // Message table entry and send command
    typedef struct packed {
        node_id_t dest;
        msg_len_t length;
    } msg_cfg_t;

    // Address map
    localparam logic [15:0] NODE_ID_ADDR   = 16'h1000;
    localparam logic [15:0] SEND_ADDR      = 16'h1004;
    localparam logic [15:0] MSG_TABLE_ADDR = 16'h1100;
    localparam logic [15:0] TX_WIN_START   = 16'h2000;
    localparam logic [15:0] TX_WIN_END     = 16'h21FC;
    localparam logic [15:0] RX_WIN_START   = 16'h3000;
    localparam logic [15:0] RX_WIN_END     = 16'h31FC;
    localparam logic [15:0] REQ_FIFO_ADDR  = 16'h3400;
    localparam logic [15:0] STATUS_ADDR    = 16'h3500;

    // Read data returned with an error response
    localparam word_t BAD_DATA = 32'hBAD1BAD1;

endpackage

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH = 8,
    parameter type T     = logic [31:0]
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  T                             push_data,
    input  logic                         pop,
    output T                             pop_data,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(DEPTH+1)-1:0]   count
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(DEPTH - 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Pointers wrap explicitly so DEPTH need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_PTR) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == FULL_COUNT);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read of the head entry
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/endpoint_regs.sv
`timescale 1ns/1ps

module endpoint_regs #(
    parameter int NUM_MSGS = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  endpoint_pkg::bus_req_t bus,
    output endpoint_pkg::bus_rsp_t bus_rsp,
    output endpoint_pkg::node_id_t node_id,
    output logic                   tx_start,
    output endpoint_pkg::msg_cfg_t tx_cmd,
    input  logic                   tx_busy,
    output logic                   tx_push,
    input  logic                   tx_full,
    input  endpoint_pkg::tx_level_t tx_count,
    output logic                   rx_pop,
    input  endpoint_pkg::word_t    rx_data,
    input  logic                   rx_empty,
    output logic                   meta_pop,
    input  endpoint_pkg::rx_meta_t meta_data,
    input  logic                   meta_empty
);
    import endpoint_pkg::*;

    localparam int IDX_W = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1;
    localparam logic [15:0] MSG_TABLE_END = MSG_TABLE_ADDR + 16'(4 * NUM_MSGS);

    msg_cfg_t          msg_table [NUM_MSGS];
    logic [IDX_W-1:0]  send_idx;
    logic [IDX_W-1:0]  table_idx;
    logic [15:0]       table_off;
    msg_cfg_t          send_entry;
    logic              send_bad;
    logic              send_ok;
    logic              node_we;
    logic              table_we;
    logic              any_strobe;

    assign any_strobe = bus.wen || bus.ren;

    // Send index comes from the write data, table index from the word address
    assign send_idx   = bus.wdata[IDX_W-1:0];
    assign send_entry = msg_table[send_idx];
    assign table_off  = bus.addr - MSG_TABLE_ADDR;
    assign table_idx  = table_off[IDX_W+1:2];

    // A pending tx_start counts as busy, the engine has not raised tx_busy yet
    assign send_bad = (bus.wdata >= word_t'(NUM_MSGS))
                   || (tx_count < tx_level_t'(send_entry.length))
                   || tx_busy
                   || tx_start;

    always_comb begin
        bus_rsp  = '0;
        tx_push  = 1'b0;
        rx_pop   = 1'b0;
        meta_pop = 1'b0;
        send_ok  = 1'b0;
        node_we  = 1'b0;
        table_we = 1'b0;

        if (any_strobe) begin
            if (bus.addr == NODE_ID_ADDR) begin
                node_we       = bus.wen;
                bus_rsp.rdata = word_t'(node_id);
            end else if (bus.addr == SEND_ADDR) begin
                // Write only
                if (bus.ren || send_bad) begin
                    bus_rsp.error = 1'b1;
                end else begin
                    send_ok = 1'b1;
                end
            end else if (bus.addr >= MSG_TABLE_ADDR && bus.addr < MSG_TABLE_END) begin
                table_we      = bus.wen;
                bus_rsp.rdata = word_t'(msg_table[table_idx]);
            end else if (bus.addr >= TX_WIN_START && bus.addr <= TX_WIN_END) begin
                if (bus.ren || tx_full) begin
                    bus_rsp.error = 1'b1;
                end else begin
                    tx_push = 1'b1;
                end
            end else if (bus.addr >= RX_WIN_START && bus.addr <= RX_WIN_END) begin
                if (bus.wen || rx_empty) begin
                    bus_rsp.error = 1'b1;
                end else begin
                    rx_pop        = 1'b1;
                    bus_rsp.rdata = rx_data;
                end
            end else if (bus.addr == REQ_FIFO_ADDR) begin
                if (bus.wen || meta_empty) begin
                    bus_rsp.error = 1'b1;
                end else begin
                    meta_pop      = 1'b1;
                    bus_rsp.rdata = word_t'(meta_data);
                end
            end else if (bus.addr == STATUS_ADDR) begin
                // Read only
                bus_rsp.error = bus.wen;
                bus_rsp.rdata = {29'd0, tx_busy, meta_empty, rx_empty};
            end else begin
                bus_rsp.error = 1'b1;
            end
        end

        if (bus_rsp.error) begin
            bus_rsp.rdata = BAD_DATA;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            node_id   <= '0;
            tx_start  <= 1'b0;
            msg_table <= '{default: '0};
        end else begin
            tx_start <= send_ok;
            if (node_we) begin
                node_id <= bus.wdata[3:0];
            end
            if (table_we) begin
                msg_table[table_idx] <= msg_cfg_t'(bus.wdata[11:0]);
            end
        end
    end

    // Command is captured with the trigger and held for the engine
    always_ff @(posedge clk) begin
        if (send_ok) begin
            tx_cmd <= send_entry;
        end
    end

endmodule

//--- logic/tx_fsm.sv
`timescale 1ns/1ps

module tx_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tx_start,
    input  endpoint_pkg::msg_cfg_t tx_cmd,
    input  endpoint_pkg::node_id_t node_id,
    output logic                   tx_busy,
    output logic                   tx_pop,
    input  endpoint_pkg::word_t    tx_data,
    output endpoint_pkg::flit_t    link_out
);
    import endpoint_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HEADER,
        TX_PAYLOAD
    } tx_state_t;

    tx_state_t state;
    msg_cfg_t  cmd_q;
    msg_len_t  remaining;
    header_t   hdr;

    always_comb begin
        hdr.dest     = cmd_q.dest;
        hdr.src      = node_id;
        hdr.length   = cmd_q.length;
        hdr.reserved = '0;
    end

    assign tx_busy = (state != TX_IDLE);

    // Every payload cycle consumes the FIFO head
    assign tx_pop = (state == TX_PAYLOAD);

    always_comb begin
        link_out = '0;
        case (state)
            TX_HEADER: begin
                link_out.valid = 1'b1;
                link_out.data  = word_t'(hdr);
            end
            TX_PAYLOAD: begin
                link_out.valid = 1'b1;
                link_out.data  = tx_data;
            end
            default: begin
                link_out = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TX_IDLE;
            remaining <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx_start) begin
                        state <= TX_HEADER;
                    end
                end
                TX_HEADER: begin
                    remaining <= cmd_q.length;
                    // Header-only message
                    state <= (cmd_q.length == '0) ? TX_IDLE : TX_PAYLOAD;
                end
                TX_PAYLOAD: begin
                    remaining <= remaining - 1'b1;
                    if (remaining == msg_len_t'(1)) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            cmd_q <= tx_cmd;
        end
    end

endmodule

//--- logic/rx_fsm.sv
`timescale 1ns/1ps

module rx_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  endpoint_pkg::flit_t    link_in,
    input  endpoint_pkg::node_id_t node_id,
    output logic                   rx_push,
    output endpoint_pkg::word_t    rx_push_data,
    input  logic                   rx_full,
    output logic                   meta_push,
    output endpoint_pkg::rx_meta_t meta_push_data,
    input  logic                   meta_full,
    output logic                   packet_recv
);
    import endpoint_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACCEPT,
        RX_DISCARD
    } rx_state_t;

    rx_state_t state;
    msg_len_t  remaining;
    node_id_t  src_q;
    msg_len_t  len_q;
    logic      ovf_q;
    header_t   hdr;
    logic      for_us;
    logic      last_word;

    assign hdr       = header_t'(link_in.data);
    assign for_us    = (hdr.dest == node_id);
    assign last_word = (remaining == msg_len_t'(1));

    assign rx_push_data = link_in.data;

    always_comb begin
        rx_push                 = 1'b0;
        meta_push               = 1'b0;
        meta_push_data.src      = src_q;
        meta_push_data.length   = len_q;
        meta_push_data.overflow = ovf_q || rx_full;
        case (state)
            RX_IDLE: begin
                // Zero-length packet ends on its header
                if (link_in.valid && for_us && hdr.length == '0) begin
                    meta_push               = !meta_full;
                    meta_push_data.src      = hdr.src;
                    meta_push_data.length   = hdr.length;
                    meta_push_data.overflow = 1'b0;
                end
            end
            RX_ACCEPT: begin
                if (link_in.valid) begin
                    // Words that find the FIFO full are dropped
                    rx_push   = !rx_full;
                    meta_push = last_word && !meta_full;
                end
            end
            default: begin
                rx_push   = 1'b0;
                meta_push = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RX_IDLE;
            remaining   <= '0;
            ovf_q       <= 1'b0;
            packet_recv <= 1'b0;
        end else begin
            packet_recv <= meta_push;
            if (link_in.valid) begin
                case (state)
                    RX_IDLE: begin
                        remaining <= hdr.length;
                        ovf_q     <= 1'b0;
                        if (hdr.length != '0) begin
                            state <= for_us ? RX_ACCEPT : RX_DISCARD;
                        end
                    end
                    RX_ACCEPT: begin
                        remaining <= remaining - 1'b1;
                        ovf_q     <= ovf_q || rx_full;
                        if (last_word) begin
                            state <= RX_IDLE;
                        end
                    end
                    RX_DISCARD: begin
                        remaining <= remaining - 1'b1;
                        if (last_word) begin
                            state <= RX_IDLE;
                        end
                    end
                    default: begin
                        state <= RX_IDLE;
                    end
                endcase
            end
        end
    end

    // Header fields kept for the metadata record
    always_ff @(posedge clk) begin
        if (state == RX_IDLE && link_in.valid) begin
            src_q <= hdr.src;
            len_q <= hdr.length;
        end
    end

endmodule

//--- logic/endpoint_top.sv
`timescale 1ns/1ps

module endpoint_top #(
    parameter int NUM_MSGS  = 4,
    parameter int TX_DEPTH  = 16,
    parameter int RX_DEPTH  = 8,
    parameter int REQ_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  endpoint_pkg::bus_req_t bus,
    output endpoint_pkg::bus_rsp_t bus_rsp,
    output endpoint_pkg::flit_t    link_out,
    input  endpoint_pkg::flit_t    link_in,
    output logic                   packet_recv
);
    import endpoint_pkg::*;

    node_id_t node_id;
    msg_cfg_t tx_cmd;
    logic     tx_start;
    logic     tx_busy;

    // Transmit FIFO
    logic                            tx_push;
    logic                            tx_pop;
    logic                            tx_full;
    word_t                           tx_data;
    logic [$clog2(TX_DEPTH+1)-1:0]   tx_count;

    // Receive FIFO
    logic  rx_push;
    logic  rx_pop;
    logic  rx_full;
    logic  rx_empty;
    word_t rx_push_data;
    word_t rx_data;

    // Request FIFO
    logic     meta_push;
    logic     meta_pop;
    logic     meta_full;
    logic     meta_empty;
    rx_meta_t meta_push_data;
    rx_meta_t meta_data;

    endpoint_regs #(
        .NUM_MSGS(NUM_MSGS)
    ) regs_i (
        .clk(clk),
        .reset(reset),
        .bus(bus),
        .bus_rsp(bus_rsp),
        .node_id(node_id),
        .tx_start(tx_start),
        .tx_cmd(tx_cmd),
        .tx_busy(tx_busy),
        .tx_push(tx_push),
        .tx_full(tx_full),
        .tx_count(tx_level_t'(tx_count)),
        .rx_pop(rx_pop),
        .rx_data(rx_data),
        .rx_empty(rx_empty),
        .meta_pop(meta_pop),
        .meta_data(meta_data),
        .meta_empty(meta_empty)
    );

    tx_fsm tx_fsm_i (
        .clk(clk),
        .reset(reset),
        .tx_start(tx_start),
        .tx_cmd(tx_cmd),
        .node_id(node_id),
        .tx_busy(tx_busy),
        .tx_pop(tx_pop),
        .tx_data(tx_data),
        .link_out(link_out)
    );

    rx_fsm rx_fsm_i (
        .clk(clk),
        .reset(reset),
        .link_in(link_in),
        .node_id(node_id),
        .rx_push(rx_push),
        .rx_push_data(rx_push_data),
        .rx_full(rx_full),
        .meta_push(meta_push),
        .meta_push_data(meta_push_data),
        .meta_full(meta_full),
        .packet_recv(packet_recv)
    );

    // Outgoing payload, filled straight from bus write data
    sync_fifo #(
        .DEPTH(TX_DEPTH),
        .T(word_t)
    ) tx_fifo (
        .clk(clk),
        .reset(reset),
        .push(tx_push),
        .push_data(bus.wdata),
        .pop(tx_pop),
        .pop_data(tx_data),
        .full(tx_full),
        .empty(),
        .count(tx_count)
    );

    sync_fifo #(
        .DEPTH(RX_DEPTH),
        .T(word_t)
    ) rx_fifo (
        .clk(clk),
        .reset(reset),
        .push(rx_push),
        .push_data(rx_push_data),
        .pop(rx_pop),
        .pop_data(rx_data),
        .full(rx_full),
        .empty(rx_empty),
        .count()
    );

    sync_fifo #(
        .DEPTH(REQ_DEPTH),
        .T(rx_meta_t)
    ) req_fifo (
        .clk(clk),
        .reset(reset),
        .push(meta_push),
        .push_data(meta_push_data),
        .pop(meta_pop),
        .pop_data(meta_data),
        .full(meta_full),
        .empty(meta_empty),
        .count()
    );

endmodule

//--- testbench/endpoint_tb.sv
`timescale 1ns/1ps

module endpoint_tb;
    import endpoint_pkg::*;

    localparam int NUM_MSGS = 4;
    localparam int TX_DEPTH = 16;
    localparam int RX_DEPTH = 8;

    // Watchdog budget in clock cycles with one term per test group
    localparam int RESET_CYCLES = 40;
    localparam int TX_CYCLES    = NUM_MSGS * (5 * TX_DEPTH + 30);
    localparam int RX_CYCLES    = 6 * (6 * (RX_DEPTH + 3) + 60);
    localparam int ERR_CYCLES   = 8 * TX_DEPTH + 120;
    localparam int WATCHDOG_NS  =
        2 * 8 * (RESET_CYCLES + TX_CYCLES + RX_CYCLES + ERR_CYCLES) + 1000;

    typedef struct packed {
        word_t       data;
        logic [31:0] cycle;
    } seen_flit_t;

    typedef struct packed {
        word_t data;
        logic  first;
    } exp_flit_t;

    logic     clk;
    logic     reset;
    bus_req_t bus;
    bus_rsp_t bus_rsp;
    flit_t    link_out;
    flit_t    link_in;
    logic     packet_recv;

    integer      seed = 32'hedb70a8e;
    int          errors = 0;
    int          checks = 0;
    int          flit_errors = 0;
    int          flit_checks = 0;
    int          recv_count = 0;
    logic [31:0] cycle_count = '0;
    node_id_t    my_node;
    node_id_t    tbl_dest [NUM_MSGS];
    msg_len_t    tbl_len [NUM_MSGS];
    word_t       tx_model[$];
    word_t       rx_model[$];
    exp_flit_t   exp_q[$];
    seen_flit_t  got_q[$];

    endpoint_top dut_i (
        .clk(clk),
        .reset(reset),
        .bus(bus),
        .bus_rsp(bus_rsp),
        .link_out(link_out),
        .link_in(link_in),
        .packet_recv(packet_recv)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 32'd1;
    end

    // Header word as laid out on the link
    function automatic word_t expected_header(input node_id_t dest, input node_id_t src,
                                              input msg_len_t length);
        return {dest, src, length, 16'h0000};
    endfunction

    // Request FIFO read word
    function automatic word_t meta_word(input node_id_t src, input msg_len_t length,
                                        input logic overflow);
        return {19'd0, src, length, overflow};
    endfunction

    function automatic int random_in_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    task automatic check_equal(input string what, input word_t got, input word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // One bus cycle with the response sampled mid-cycle and the side effect at the next edge
    task automatic bus_access(input logic [15:0] addr, input logic wen, input logic ren,
                              input word_t wdata, output word_t rdata, output logic err);
        @(posedge clk);
        bus <= '{addr: addr, wen: wen, ren: ren, wdata: wdata};
        @(negedge clk);
        rdata = bus_rsp.rdata;
        err   = bus_rsp.error;
        @(posedge clk);
        bus <= '0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input word_t wdata, output logic err);
        word_t rd;
        bus_access(addr, 1'b1, 1'b0, wdata, rd, err);
    endtask

    task automatic bus_read(input logic [15:0] addr, output word_t rdata, output logic err);
        bus_access(addr, 1'b0, 1'b1, 32'd0, rdata, err);
    endtask

    task automatic check_status(input word_t want);
        word_t rd;
        logic  err;
        bus_read(STATUS_ADDR, rd, err);
        check_equal("status error flag", word_t'(err), 32'd0);
        check_equal("status word", rd, want);
    endtask

    task automatic write_entry(input int idx, input node_id_t dest, input msg_len_t length);
        word_t rd;
        logic  err;
        bus_write(MSG_TABLE_ADDR + 16'(4 * idx), {20'd0, dest, length}, err);
        check_equal("table write error flag", word_t'(err), 32'd0);
        bus_read(MSG_TABLE_ADDR + 16'(4 * idx), rd, err);
        check_equal("table readback", rd, {20'd0, dest, length});
        tbl_dest[idx] = dest;
        tbl_len[idx]  = length;
    endtask

    // A push is refused once TX_DEPTH words wait in the FIFO
    task automatic push_word(input word_t value);
        logic err;
        logic full;
        full = (tx_model.size() >= TX_DEPTH);
        bus_write(TX_WIN_START + 16'((tx_model.size() & 127) << 2), value, err);
        check_equal("tx push error flag", word_t'(err), word_t'(full));
        if (!full) begin
            tx_model.push_back(value);
        end
    endtask

    task automatic send_msg(input int idx, input logic expect_err);
        logic      err;
        exp_flit_t e;
        bus_write(SEND_ADDR, word_t'(idx), err);
        check_equal("send error flag", word_t'(err), word_t'(expect_err));
        if (!expect_err) begin
            e.data  = expected_header(tbl_dest[idx], my_node, tbl_len[idx]);
            e.first = 1'b1;
            exp_q.push_back(e);
            repeat (tbl_len[idx]) begin
                e.data  = tx_model.pop_front();
                e.first = 1'b0;
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_tx_done();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 4 * TX_DEPTH + 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            $display("Transmit did not finish, %0d expected flits never appeared on link_out",
                     exp_q.size());
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic drive_flit(input word_t value);
        @(posedge clk);
        link_in <= '{valid: 1'b1, data: value};
    endtask

    task automatic inject_packet(input node_id_t dest, input node_id_t src, input int len);
        word_t w;
        int    gap;
        drive_flit(expected_header(dest, src, msg_len_t'(len)));
        for (int i = 0; i < len; i++) begin
            gap = random_in_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                link_in <= '0;
            end
            w = $random(seed);
            drive_flit(w);
            // Only the first RX_DEPTH words of a packet fit
            if (dest == my_node && rx_model.size() < RX_DEPTH) begin
                rx_model.push_back(w);
            end
        end
        @(posedge clk);
        link_in <= '0;
    endtask

    task automatic expect_one_pulse(input int base);
        int n;
        n = 0;
        while (recv_count == base && n < 40) begin
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
        checks++;
        if (recv_count != base + 1) begin
            errors++;
            $display("error at %0d ns: packet_recv high for %0d cycles, expected 1",
                     $time, recv_count - base);
        end
    endtask

    task automatic check_meta(input node_id_t src, input msg_len_t length, input logic ovf);
        word_t rd;
        logic  err;
        bus_read(REQ_FIFO_ADDR, rd, err);
        check_equal("request pop error flag", word_t'(err), 32'd0);
        check_equal("request word", rd, meta_word(src, length, ovf));
    endtask

    task automatic check_rx_data();
        word_t rd;
        logic  err;
        for (int i = 0; i < rx_model.size(); i++) begin
            bus_read(RX_WIN_START + 16'(4 * i), rd, err);
            check_equal("rx pop error flag", word_t'(err), 32'd0);
            check_equal("rx payload word", rd, rx_model[i]);
        end
        rx_model.delete();
        check_status(32'h3);
    endtask

    initial begin : flit_monitor
        seen_flit_t seen;
        forever begin
            @(negedge clk);
            if (!reset && link_out.valid) begin
                seen.data  = link_out.data;
                seen.cycle = cycle_count;
                got_q.push_back(seen);
            end
        end
    end

    initial begin : pulse_counter
        forever begin
            @(negedge clk);
            if (!reset && packet_recv) begin
                recv_count++;
            end
        end
    end

    // Payload flits must follow their header with no idle cycle
    initial begin : compare_flits
        seen_flit_t  got;
        exp_flit_t   want;
        logic [31:0] last_cycle;
        last_cycle = '0;
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                got = got_q.pop_front();
                flit_checks++;
                if (exp_q.size() == 0) begin
                    flit_errors++;
                    $display("error at %0d ns: unexpected flit %h on link_out", $time, got.data);
                end else begin
                    want = exp_q.pop_front();
                    if (got.data !== want.data) begin
                        flit_errors++;
                        $display("error at %0d ns: link_out flit %h, expected %h",
                                 $time, got.data, want.data);
                    end
                    if (!want.first && got.cycle != last_cycle + 32'd1) begin
                        flit_errors++;
                        $display("error at %0d ns: gap before payload flit %h",
                                 $time, got.data);
                    end
                end
                last_cycle = got.cycle;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("The run timed out after %0d ns without finishing its tests", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin : main_sequence
        word_t    rd;
        logic     err;
        node_id_t src;
        int       len;
        int       base;
        reset   = 1'b1;
        bus     = '0;
        link_in = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Reset state
        check_equal("link_out.valid after reset", word_t'(link_out.valid), 32'd0);
        check_equal("packet_recv after reset", word_t'(packet_recv), 32'd0);
        check_equal("idle read data", bus_rsp.rdata, 32'd0);
        check_equal("idle error flag", word_t'(bus_rsp.error), 32'd0);
        check_status(32'h3);
        bus_read(NODE_ID_ADDR, rd, err);
        check_equal("node id after reset", rd, 32'd0);

        // Transmit, one message per table entry
        my_node = node_id_t'(random_in_range(1, 15));
        bus_write(NODE_ID_ADDR, word_t'(my_node), err);
        bus_read(NODE_ID_ADDR, rd, err);
        check_equal("node id readback", rd, word_t'(my_node));
        for (int idx = 0; idx < NUM_MSGS; idx++) begin
            len = random_in_range(1, TX_DEPTH);
            write_entry(idx, node_id_t'(random_in_range(0, 15)), msg_len_t'(len));
            repeat (len) push_word($random(seed));
            send_msg(idx, 1'b0);
            wait_tx_done();
        end

        // Receive
        for (int p = 0; p < 3; p++) begin
            base = recv_count;
            src  = node_id_t'(random_in_range(0, 15));
            len  = random_in_range(0, RX_DEPTH);
            inject_packet(my_node, src, len);
            expect_one_pulse(base);
            check_meta(src, msg_len_t'(len), 1'b0);
            check_rx_data();
        end

        // Packet for another node, then one for this node
        base = recv_count;
        inject_packet(my_node + 4'd1, node_id_t'(random_in_range(0, 15)),
                      random_in_range(1, RX_DEPTH));
        src = node_id_t'(random_in_range(0, 15));
        len = random_in_range(1, RX_DEPTH);
        inject_packet(my_node, src, len);
        expect_one_pulse(base);
        check_meta(src, msg_len_t'(len), 1'b0);
        bus_read(REQ_FIFO_ADDR, rd, err);
        check_equal("second request pop error flag", word_t'(err), 32'd1);
        check_rx_data();

        // Overflow of the receive FIFO
        base = recv_count;
        src  = node_id_t'(random_in_range(0, 15));
        inject_packet(my_node, src, RX_DEPTH + 3);
        expect_one_pulse(base);
        check_meta(src, msg_len_t'(RX_DEPTH + 3), 1'b1);
        check_rx_data();

        // Error responses
        write_entry(0, node_id_t'(random_in_range(0, 15)), msg_len_t'(5));
        repeat (3) push_word($random(seed));
        send_msg(0, 1'b0 | 1'b1);
        repeat (7) push_word($random(seed));
        // Enough words wait here, so only the index is out of range
        send_msg(NUM_MSGS, 1'b1);
        send_msg(0, 1'b0);
        send_msg(0, 1'b1);
        wait_tx_done();
        send_msg(0, 1'b0);
        wait_tx_done();
        repeat (TX_DEPTH + 1) push_word($random(seed));
        write_entry(1, node_id_t'(random_in_range(0, 15)), msg_len_t'(TX_DEPTH));
        send_msg(1, 1'b0);
        wait_tx_done();
        bus_read(RX_WIN_START, rd, err);
        check_equal("empty rx pop error flag", word_t'(err), 32'd1);
        check_equal("empty rx pop data", rd, 32'hBAD1BAD1);
        bus_read(REQ_FIFO_ADDR, rd, err);
        check_equal("empty request pop error flag", word_t'(err), 32'd1);
        bus_write(16'h5000, $random(seed), err);
        check_equal("unmapped write error flag", word_t'(err), 32'd1);
        check_status(32'h3);

        repeat (5) @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checks + flit_checks, errors + flit_errors);
        if (errors + flit_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/endpoint_pkg.sv
logic/sync_fifo.sv
logic/endpoint_regs.sv
logic/tx_fsm.sv
logic/rx_fsm.sv
logic/endpoint_top.sv
testbench/endpoint_tb.sv

//--- Makefile
TOP = endpoint_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log
